// File: common/cn_macros.svh
`ifndef CN_MACROS_SVH
`define CN_MACROS_SVH

// trigger strobe bit positions, one parameter per bit
`define CN_TRIG_IA_GAIN     1
`define CN_TRIG_II_GAIN     2
`define CN_TRIG_PROPORTION  4
`define CN_TRIG_OFFSET      6
`define CN_TRIG_EXTRA       8
`define CN_TRIG_SYN_GAIN    13

// q8.8 gain constants
`define CN_GAIN_ONE         16'd256    // 1.0
`define CN_SYN_GAIN_RESET   16'd512    // 2.0
`define CN_GAIN_FRAC        8          // fraction bits

// synapse
`define CN_SYN_AMP          32'd1024   // kick per afferent spike
`define CN_SYN_DECAY_SHIFT  3          // leak of cur/8 per step

// drive scaling
`define CN_COMP_SHIFT       9          // neuron compensation
`define CN_EXTRA_SHIFT      4          // tonic cortical drive

// neuron
`define CN_NEURON_IN_SHIFT  8
`define CN_THRESHOLD        32'd30720  // 30 mv scaled by 2^10

`endif

// File: common/cn_pkg.sv
package cn_pkg;

    // raw 32 bit load word from the host side
    typedef logic [31:0] cn_word_t;

    // unsigned q8.8, 256 is unity
    typedef logic [15:0] cn_gain_t;

    // currents, drives and membrane potential all share this width
    typedef logic [31:0] cn_current_t;

    // one-hot load strobes
    typedef logic [15:0] cn_trig_t;

    // loadable model parameters
    typedef struct packed {
        cn_gain_t    ia_gain;      // weight of the ia afferent
        cn_gain_t    ii_gain;      // weight of the ii afferent
        cn_gain_t    syn_gain;     // common synaptic gain
        cn_gain_t    proportion;   // share sent to the overflow neuron
        cn_current_t offset;       // subtracted from raw drive
        cn_current_t extra_drive;  // tonic cortical input
    } cn_params_t;

    // synaptic currents per afferent
    typedef struct packed {
        cn_current_t ia_current;
        cn_current_t ii_current;
    } cn_syn_t;

    // drives into the two neurons
    typedef struct packed {
        cn_current_t main_drive;
        cn_current_t overflow_drive;
    } cn_drive_t;

endpackage

// File: rtl/cn_param_bank.sv
`include "cn_macros.svh"

module cn_param_bank (
    input  logic               ep50trig,
    input  logic               reset_global,
    input  cn_pkg::cn_trig_t   i_trig,       // one-hot load strobes
    input  cn_pkg::cn_word_t   i_trig_data,  // value to load
    output cn_pkg::cn_params_t o_params
);

    // gains only keep the low half of the load word
    cn_pkg::cn_gain_t gain_data;

    assign gain_data = i_trig_data[15:0];

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            // physiological defaults
            o_params.ia_gain     <= `CN_GAIN_ONE;
            o_params.ii_gain     <= `CN_GAIN_ONE;
            o_params.syn_gain    <= `CN_SYN_GAIN_RESET;   // 2.0
            o_params.proportion  <= `CN_GAIN_ONE;         // full share to overflow
            o_params.offset      <= '0;
            o_params.extra_drive <= '0;
        end else begin
            // each field watches its own strobe bit, several may fire together
            if (i_trig[`CN_TRIG_IA_GAIN]) begin
                o_params.ia_gain <= gain_data;
            end
            if (i_trig[`CN_TRIG_II_GAIN]) begin
                o_params.ii_gain <= gain_data;
            end
            if (i_trig[`CN_TRIG_SYN_GAIN]) begin
                o_params.syn_gain <= gain_data;
            end
            if (i_trig[`CN_TRIG_PROPORTION]) begin
                o_params.proportion <= gain_data;  // 0 mutes the overflow neuron
            end
            if (i_trig[`CN_TRIG_OFFSET]) begin
                o_params.offset <= i_trig_data;
            end
            if (i_trig[`CN_TRIG_EXTRA]) begin
                o_params.extra_drive <= i_trig_data;  // scaled later in drive stage
            end
        end
    end

endmodule

// File: rtl/cn_synapse_stage.sv
`include "cn_macros.svh"

module cn_synapse_stage (
    input  logic            ep50trig,
    input  logic            reset_global,
    input  logic            i_sim_reset,  // sync clear of model state
    input  logic            i_spike_ia,   // ia afferent spike level
    input  logic            i_spike_ii,   // ii afferent spike level
    output cn_pkg::cn_syn_t o_syn
);

    cn_pkg::cn_current_t ia_next;
    cn_pkg::cn_current_t ii_next;

    // one exponential synapse step
    // leak by cur >> shift, then add the kick if the afferent fired
    function automatic cn_pkg::cn_current_t syn_next(
        input cn_pkg::cn_current_t cur,
        input logic                spike
    );
        cn_pkg::cn_current_t leaked;
        leaked = cur - (cur >> `CN_SYN_DECAY_SHIFT);
        if (spike) begin
            leaked = leaked + `CN_SYN_AMP;
        end
        return leaked;
    endfunction

    assign ia_next = syn_next(o_syn.ia_current, i_spike_ia);
    assign ii_next = syn_next(o_syn.ii_current, i_spike_ii);

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_syn <= '0;
        end else if (i_sim_reset) begin
            o_syn <= '0;  // spikes during sim reset are dropped
        end else begin
            o_syn.ia_current <= ia_next;
            o_syn.ii_current <= ii_next;
        end
    end

endmodule

// File: rtl/cn_drive_stage.sv
`include "cn_macros.svh"

module cn_drive_stage (
    input  logic               ep50trig,
    input  logic               reset_global,
    input  cn_pkg::cn_syn_t    i_syn,
    input  cn_pkg::cn_params_t i_params,
    output cn_pkg::cn_current_t o_raw_drive
);

    // all arithmetic here wraps at 32 bits
    cn_pkg::cn_current_t ia_gain_ext;
    cn_pkg::cn_current_t ii_gain_ext;
    cn_pkg::cn_current_t syn_gain_ext;
    cn_pkg::cn_current_t ia_weighted;    // q8.8 scaled
    cn_pkg::cn_current_t ii_weighted;    // q8.8 scaled
    cn_pkg::cn_current_t afferent_sum;   // back to integer
    cn_pkg::cn_current_t syn_product;
    cn_pkg::cn_current_t syn_scaled;
    cn_pkg::cn_current_t compensated;    // sensory part of drive
    cn_pkg::cn_current_t extra_scaled;   // tonic part of drive
    cn_pkg::cn_current_t raw_drive_d;

    // zero extend gains to the current width
    assign ia_gain_ext  = {16'd0, i_params.ia_gain};
    assign ii_gain_ext  = {16'd0, i_params.ii_gain};
    assign syn_gain_ext = {16'd0, i_params.syn_gain};

    // weight each afferent
    assign ia_weighted = i_syn.ia_current * ia_gain_ext;
    assign ii_weighted = i_syn.ii_current * ii_gain_ext;

    // merge then drop the gain fraction
    assign afferent_sum = (ia_weighted + ii_weighted) >> `CN_GAIN_FRAC;

    // common synaptic gain
    assign syn_product = afferent_sum * syn_gain_ext;
    assign syn_scaled  = syn_product >> `CN_GAIN_FRAC;

    // neuron compensation applied after the gain
    assign compensated = syn_scaled << `CN_COMP_SHIFT;

    // cortical drive enters with its own fixed scale
    assign extra_scaled = i_params.extra_drive << `CN_EXTRA_SHIFT;

    assign raw_drive_d = compensated + extra_scaled;

    // drive latch, new value every step
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_raw_drive <= '0;
        end else begin
            o_raw_drive <= raw_drive_d;
        end
    end

endmodule

// File: rtl/cn_offset_stage.sv
`include "cn_macros.svh"

module cn_offset_stage (
    input  logic                ep50trig,
    input  logic                reset_global,
    input  cn_pkg::cn_current_t i_raw_drive,  // latched drive
    input  cn_pkg::cn_params_t  i_params,
    output cn_pkg::cn_drive_t   o_drive
);

    cn_pkg::cn_current_t main_drive_d;
    logic [47:0]         overflow_prod;  // 32 x 16 full product
    cn_pkg::cn_drive_t   drive_d;

    // offset with floor at zero, equal values give 0 too
    assign main_drive_d = (i_raw_drive > i_params.offset) ?
                          (i_raw_drive - i_params.offset) : '0;

    // proportion of the main drive, kept wide so 1.0 passes unchanged
    assign overflow_prod = {16'd0, main_drive_d} * {32'd0, i_params.proportion};

    always_comb begin
        drive_d.main_drive     = main_drive_d;
        drive_d.overflow_drive = overflow_prod[`CN_GAIN_FRAC +: 32];  // drop q8.8 fraction
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_drive <= '0;
        end else begin
            o_drive <= drive_d;  // both neuron drives move together
        end
    end

endmodule

// File: rtl/iaf_neuron.sv
`include "cn_macros.svh"

module iaf_neuron (
    input  logic                ep50trig,
    input  logic                reset_global,
    input  logic                i_sim_reset,  // clears the membrane
    input  cn_pkg::cn_current_t i_drive,
    output logic                o_spike       // one cycle per firing
);

    cn_pkg::cn_current_t v_mem;  // membrane potential
    cn_pkg::cn_current_t v_sum;  // potential after this step's input

    // integrate the scaled drive, no leak
    assign v_sum = v_mem + (i_drive >> `CN_NEURON_IN_SHIFT);

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            v_mem   <= '0;
            o_spike <= 1'b0;
        end else if (i_sim_reset) begin
            v_mem   <= '0;
            o_spike <= 1'b0;
        end else if (v_sum >= `CN_THRESHOLD) begin
            v_mem   <= '0;    // fire and restart from rest
            o_spike <= 1'b1;
        end else begin
            v_mem   <= v_sum;
            o_spike <= 1'b0;  // pulse lasts a single step
        end
    end

endmodule

// File: rtl/cn_top.sv
module cn_top (
    input  logic                ep50trig,
    input  logic                reset_global,
    input  logic                i_sim_reset,
    input  cn_pkg::cn_trig_t    i_trig,
    input  cn_pkg::cn_word_t    i_trig_data,
    input  logic                i_spike_ia,
    input  logic                i_spike_ii,
    output cn_pkg::cn_current_t o_main_drive,
    output cn_pkg::cn_current_t o_overflow_drive,
    output logic                o_spike_main,
    output logic                o_spike_overflow,
    output cn_pkg::cn_current_t o_sim_time  // model step count
);

    cn_pkg::cn_params_t  params;
    cn_pkg::cn_syn_t     syn;        // stage 1 out
    cn_pkg::cn_current_t raw_drive;  // stage 2 out
    cn_pkg::cn_drive_t   drive;      // stage 3 out

    cn_param_bank u_param_bank (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_trig_data  (i_trig_data),
        .o_params     (params)
    );

    cn_synapse_stage u_synapse_stage (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_spike_ia   (i_spike_ia),
        .i_spike_ii   (i_spike_ii),
        .o_syn        (syn)
    );

    cn_drive_stage u_drive_stage (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_syn        (syn),
        .i_params     (params),
        .o_raw_drive  (raw_drive)
    );

    cn_offset_stage u_offset_stage (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_raw_drive  (raw_drive),
        .i_params     (params),
        .o_drive      (drive)
    );

    // main cn neuron
    iaf_neuron u_main (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_drive      (drive.main_drive),
        .o_spike      (o_spike_main)
    );

    // overflow neuron on the proportioned drive
    iaf_neuron u_overflow (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_sim_reset  (i_sim_reset),
        .i_drive      (drive.overflow_drive),
        .o_spike      (o_spike_overflow)
    );

    assign o_main_drive     = drive.main_drive;
    assign o_overflow_drive = drive.overflow_drive;

    // step counter, untouched by sim reset
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_sim_time <= '0;
        end else begin
            o_sim_time <= o_sim_time + 32'd1;
        end
    end

endmodule

// File: dv/cn_assertions.sv
`include "cn_macros.svh"

module cn_assertions (
    input logic                ep50trig,
    input logic                reset_global,
    input logic                i_sim_reset,
    input cn_pkg::cn_trig_t    i_trig,
    input cn_pkg::cn_word_t    i_trig_data,
    input logic                i_spike_ia,
    input logic                i_spike_ii,
    input cn_pkg::cn_current_t o_main_drive,
    input cn_pkg::cn_current_t o_overflow_drive,
    input logic                o_spike_main,
    input logic                o_spike_overflow,
    input cn_pkg::cn_current_t o_sim_time
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // read by the testbench top

    // reference model of the relay channel, built from the channel rules
    cn_pkg::cn_params_t  m_par;
    cn_pkg::cn_current_t m_ia;
    cn_pkg::cn_current_t m_ii;
    cn_pkg::cn_current_t m_raw;        // expected raw drive
    cn_pkg::cn_current_t m_main;       // expected o_main_drive
    cn_pkg::cn_current_t m_ovf;        // expected o_overflow_drive
    cn_pkg::cn_current_t m_v_main;
    cn_pkg::cn_current_t m_v_ovf;
    logic                m_spk_main;
    logic                m_spk_ovf;
    cn_pkg::cn_current_t sense;        // sensory part, wraps at 32 bits
    cn_pkg::cn_current_t raw_next;
    cn_pkg::cn_current_t main_next;
    logic [63:0]         ovf_wide;
    cn_pkg::cn_current_t v_main_sum;
    cn_pkg::cn_current_t v_ovf_sum;

    always_comb begin
        sense = ((m_ia * {16'd0, m_par.ia_gain}) + (m_ii * {16'd0, m_par.ii_gain}))
                >> `CN_GAIN_FRAC;
        sense = ((sense * {16'd0, m_par.syn_gain}) >> `CN_GAIN_FRAC) << `CN_COMP_SHIFT;
        raw_next   = sense + (m_par.extra_drive << `CN_EXTRA_SHIFT);
        main_next  = (m_raw > m_par.offset) ? (m_raw - m_par.offset) : 32'd0;  // floor at 0
        ovf_wide   = {32'd0, main_next} * {48'd0, m_par.proportion};
        v_main_sum = m_v_main + (m_main >> `CN_NEURON_IN_SHIFT);
        v_ovf_sum  = m_v_ovf + (m_ovf >> `CN_NEURON_IN_SHIFT);
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            m_par <= {`CN_GAIN_ONE, `CN_GAIN_ONE, `CN_SYN_GAIN_RESET, `CN_GAIN_ONE, 64'd0};
            m_ia       <= '0;
            m_ii       <= '0;
            m_raw      <= '0;
            m_main     <= '0;
            m_ovf      <= '0;
            m_v_main   <= '0;
            m_v_ovf    <= '0;
            m_spk_main <= 1'b0;
            m_spk_ovf  <= 1'b0;
        end else begin
            if (i_trig[`CN_TRIG_IA_GAIN])    m_par.ia_gain     <= i_trig_data[15:0];
            if (i_trig[`CN_TRIG_II_GAIN])    m_par.ii_gain     <= i_trig_data[15:0];
            if (i_trig[`CN_TRIG_SYN_GAIN])   m_par.syn_gain    <= i_trig_data[15:0];
            if (i_trig[`CN_TRIG_PROPORTION]) m_par.proportion  <= i_trig_data[15:0];
            if (i_trig[`CN_TRIG_OFFSET])     m_par.offset      <= i_trig_data;
            if (i_trig[`CN_TRIG_EXTRA])      m_par.extra_drive <= i_trig_data;
            m_raw  <= raw_next;
            m_main <= main_next;
            m_ovf  <= ovf_wide[`CN_GAIN_FRAC +: 32];  // drop q8.8 fraction
            if (i_sim_reset) begin
                // model state only, params untouched
                m_ia       <= '0;
                m_ii       <= '0;
                m_v_main   <= '0;
                m_v_ovf    <= '0;
                m_spk_main <= 1'b0;
                m_spk_ovf  <= 1'b0;
            end else begin
                m_ia <= m_ia - (m_ia >> `CN_SYN_DECAY_SHIFT) + (i_spike_ia ? `CN_SYN_AMP : 32'd0);
                m_ii <= m_ii - (m_ii >> `CN_SYN_DECAY_SHIFT) + (i_spike_ii ? `CN_SYN_AMP : 32'd0);
                m_spk_main <= (v_main_sum >= `CN_THRESHOLD);
                m_spk_ovf  <= (v_ovf_sum >= `CN_THRESHOLD);
                m_v_main   <= (v_main_sum >= `CN_THRESHOLD) ? 32'd0 : v_main_sum;
                m_v_ovf    <= (v_ovf_sum >= `CN_THRESHOLD) ? 32'd0 : v_ovf_sum;
            end
        end
    end

    // all quiet during reset and on the first step after it
    a_reset_state: assert property (@(posedge ep50trig)
        (reset_global || $fell(reset_global)) |-> (o_main_drive == 32'd0 &&
        o_overflow_drive == 32'd0 && !o_spike_main && !o_spike_overflow && o_sim_time == 32'd0))
        else begin
            fail_count++;
            $error("ERROR t=%0t reset outputs expected 0 actual main %0d ovf %0d time %0d",
                   $time, $sampled(o_main_drive), $sampled(o_overflow_drive), $sampled(o_sim_time));
        end

    a_time_step: assert property (@(posedge ep50trig) disable iff (reset_global)
        !$past(reset_global) |-> o_sim_time == $past(o_sim_time) + 32'd1)
        else begin
            fail_count++;
            $error("ERROR t=%0t o_sim_time expected %0d actual %0d", $time,
                   $past(o_sim_time) + 32'd1, $sampled(o_sim_time));
        end

    a_main_drive: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_main_drive == m_main)
        else begin
            fail_count++;
            $error("ERROR t=%0t o_main_drive expected %0d actual %0d", $time,
                   $sampled(m_main), $sampled(o_main_drive));
        end

    a_overflow_drive: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_overflow_drive == m_ovf)
        else begin
            fail_count++;
            $error("ERROR t=%0t o_overflow_drive expected %0d actual %0d", $time,
                   $sampled(m_ovf), $sampled(o_overflow_drive));
        end

    // unity proportion copies the main drive
    a_overflow_unity: assert property (@(posedge ep50trig) disable iff (reset_global)
        $past(m_par.proportion) == `CN_GAIN_ONE |-> o_overflow_drive == o_main_drive)
        else begin
            fail_count++;
            $error("ERROR t=%0t o_overflow_drive expected %0d actual %0d", $time,
                   $sampled(o_main_drive), $sampled(o_overflow_drive));
        end

    a_overflow_muted: assert property (@(posedge ep50trig) disable iff (reset_global)
        ($past(m_par.proportion) == 16'd0 && $past(m_par.proportion, 2) == 16'd0)
        |-> (o_overflow_drive == 32'd0 && !o_spike_overflow))
        else begin
            fail_count++;
            $error("ERROR t=%0t o_overflow_drive expected 0 actual %0d spike %0b", $time,
                   $sampled(o_overflow_drive), $sampled(o_spike_overflow));
        end

    a_spike_main: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike_main == m_spk_main)
        else begin
            fail_count++;
            $error("ERROR t=%0t o_spike_main expected %0b actual %0b", $time,
                   $sampled(m_spk_main), $sampled(o_spike_main));
        end

    a_spike_overflow: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike_overflow == m_spk_ovf)
        else begin
            fail_count++;
            $error("ERROR t=%0t o_spike_overflow expected %0b actual %0b", $time,
                   $sampled(m_spk_ovf), $sampled(o_spike_overflow));
        end

    // each neuron's pulse is a single step wide
    a_spike_main_width: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike_main |=> !o_spike_main)
        else begin
            fail_count++;
            $error("ERROR t=%0t o_spike_main stayed high for more than one cycle", $time);
        end

    a_spike_overflow_width: assert property (@(posedge ep50trig) disable iff (reset_global)
        o_spike_overflow |=> !o_spike_overflow)
        else begin
            fail_count++;
            $error("ERROR t=%0t o_spike_overflow stayed high for more than one cycle", $time);
        end

endmodule

// File: dv/tb_cn_top.sv
`include "cn_macros.svh"

module tb_cn_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD       = 4;
    localparam int RESET_CYCLES     = 16;
    localparam int IDLE_CYCLES      = 10;
    localparam int SETTLE_CYCLES    = 6;    // covers the 3 stage latency
    localparam int FIRE_FAST_CYCLES = 120;  // pulse every 50 steps
    localparam int RANDOM_CYCLES    = 200;
    localparam int FIRE_SLOW_CYCLES = 600;  // pulse every 246 steps
    localparam int QUIET_CYCLES     = 100;
    localparam int TEST_CYCLES      = IDLE_CYCLES + 10 * SETTLE_CYCLES + 2 * FIRE_FAST_CYCLES
                                      + 2 * RANDOM_CYCLES + FIRE_SLOW_CYCLES + QUIET_CYCLES + 40;
    localparam int WATCHDOG_CYCLES  = RESET_CYCLES + 2 * TEST_CYCLES;

    logic                ep50trig;
    logic                reset_global;
    logic                i_sim_reset;
    cn_pkg::cn_trig_t    i_trig;
    cn_pkg::cn_word_t    i_trig_data;
    logic                i_spike_ia;
    logic                i_spike_ii;
    cn_pkg::cn_current_t o_main_drive;
    cn_pkg::cn_current_t o_overflow_drive;
    logic                o_spike_main;
    logic                o_spike_overflow;
    cn_pkg::cn_current_t o_sim_time;
    logic [31:0]         rng_state;

    cn_top DUT (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_reset(i_sim_reset),
        .i_trig(i_trig), .i_trig_data(i_trig_data),
        .i_spike_ia(i_spike_ia), .i_spike_ii(i_spike_ii),
        .o_main_drive(o_main_drive), .o_overflow_drive(o_overflow_drive),
        .o_spike_main(o_spike_main), .o_spike_overflow(o_spike_overflow),
        .o_sim_time(o_sim_time)
    );

    bind cn_top cn_assertions u_assertions (
        .ep50trig(ep50trig), .reset_global(reset_global), .i_sim_reset(i_sim_reset),
        .i_trig(i_trig), .i_trig_data(i_trig_data),
        .i_spike_ia(i_spike_ia), .i_spike_ii(i_spike_ii),
        .o_main_drive(o_main_drive), .o_overflow_drive(o_overflow_drive),
        .o_spike_main(o_spike_main), .o_spike_overflow(o_spike_overflow),
        .o_sim_time(o_sim_time)
    );

    initial begin
        ep50trig = 1'b0;
        forever #(CLK_PERIOD / 2) ep50trig = ~ep50trig;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic next_cycle();
        @(posedge ep50trig);
        #1;  // drive just after the edge
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic load_param(input int trig_bit, input cn_pkg::cn_word_t value);
        i_trig      = cn_pkg::cn_trig_t'(1) << trig_bit;
        i_trig_data = value;
        next_cycle();
        i_trig      = '0;
        i_trig_data = '0;
    endtask

    task automatic pulse_sim_reset();
        i_sim_reset = 1'b1;
        next_cycle();
        i_sim_reset = 1'b0;
    endtask

    task automatic drive_random_spikes(input int n);
        repeat (n) begin
            rng_state  = xorshift32(rng_state);
            i_spike_ia = (rng_state[3:0] == 4'd0);  // about 1 in 16
            i_spike_ii = (rng_state[7:4] == 4'd0);
            next_cycle();
        end
        i_spike_ia = 1'b0;
        i_spike_ii = 1'b0;
    endtask

    // stop at the first assertion failure
    always @(negedge ep50trig) begin
        if (DUT.u_assertions.fail_count != 0) begin
            $display("Simulation FAILED");
            $fatal(1, "assertion check failed, see the ERROR line above");
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired before the stimulus finished");
    end

    initial begin
        reset_global = 1'b1;
        i_sim_reset  = 1'b0;
        i_trig       = '0;
        i_trig_data  = '0;
        i_spike_ia   = 1'b0;
        i_spike_ii   = 1'b0;
        rng_state    = 32'd73192;
        repeat (RESET_CYCLES) @(posedge ep50trig);
        #1;
        reset_global = 1'b0;
        wait_cycles(IDLE_CYCLES);            // step counter only
        load_param(`CN_TRIG_EXTRA, 32'd100);  // 1600 raw
        load_param(`CN_TRIG_OFFSET, 32'd500);
        wait_cycles(SETTLE_CYCLES);
        load_param(`CN_TRIG_OFFSET, 32'd5000);  // offset above drive, floor
        wait_cycles(SETTLE_CYCLES);
        i_trig      = (cn_pkg::cn_trig_t'(1) << `CN_TRIG_OFFSET)
                      | (cn_pkg::cn_trig_t'(1) << `CN_TRIG_EXTRA);
        i_trig_data = 32'd300;  // both load at once
        next_cycle();
        i_trig      = '0;
        i_trig_data = '0;
        wait_cycles(SETTLE_CYCLES);
        // strong tonic drive, overflow muted then at unity
        load_param(`CN_TRIG_OFFSET, 32'd0);
        load_param(`CN_TRIG_EXTRA, 32'd10000);
        load_param(`CN_TRIG_PROPORTION, 32'd0);
        wait_cycles(FIRE_FAST_CYCLES);
        load_param(`CN_TRIG_PROPORTION, {16'd0, `CN_GAIN_ONE});
        wait_cycles(FIRE_FAST_CYCLES);
        // single ia spike from zero state
        load_param(`CN_TRIG_EXTRA, 32'd0);
        load_param(`CN_TRIG_IA_GAIN, {16'd0, `CN_GAIN_ONE});
        load_param(`CN_TRIG_SYN_GAIN, {16'd0, `CN_SYN_GAIN_RESET});
        pulse_sim_reset();
        wait_cycles(SETTLE_CYCLES);
        i_spike_ia = 1'b1;
        next_cycle();
        i_spike_ia = 1'b0;
        wait_cycles(SETTLE_CYCLES);
        load_param(`CN_TRIG_II_GAIN, 32'd0);  // ii path blocked
        i_spike_ii = 1'b1;
        next_cycle();
        i_spike_ii = 1'b0;
        wait_cycles(SETTLE_CYCLES);
        drive_random_spikes(RANDOM_CYCLES);
        load_param(`CN_TRIG_II_GAIN, 32'd128);  // 0.5
        drive_random_spikes(RANDOM_CYCLES);
        // sim reset drops back to the tonic baseline
        load_param(`CN_TRIG_EXTRA, 32'd50);
        pulse_sim_reset();
        wait_cycles(SETTLE_CYCLES);
        load_param(`CN_TRIG_EXTRA, 32'd2000);  // 32000 drive, 125 per step
        pulse_sim_reset();
        wait_cycles(FIRE_SLOW_CYCLES);
        load_param(`CN_TRIG_EXTRA, 32'd0);  // no drive, no pulses
        pulse_sim_reset();
        wait_cycles(QUIET_CYCLES);
        if (DUT.u_assertions.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "assertion failures were recorded");
        end
    end

endmodule

// File: vlog.f
+incdir+common
common/cn_pkg.sv
rtl/cn_param_bank.sv
rtl/cn_synapse_stage.sv
rtl/cn_drive_stage.sv
rtl/cn_offset_stage.sv
rtl/iaf_neuron.sv
rtl/cn_top.sv
dv/cn_assertions.sv
dv/tb_cn_top.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_cn_top --Mdir obj_dir -o sim_tb_cn_top \
    -f vlog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

# raise the error limit so the testbench reports the failure itself
./obj_dir/sim_tb_cn_top +verilator+error+limit+1000
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
